/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := pito_mem_subsystem_tb
FILELIST  := sim.f
BUILD_DIR := obj_dir

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard hw/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Fails unless the pass message shows up in the simulator output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(BUILD_DIR)

/* hw/pito_addr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pito_mem_macros.svh"

module pito_addr_decoder (
  input  wire logic                   clk_i,
  input  wire logic                   rst_n_i,
  // Granted request from the arbiter
  input  wire logic                   bus_req_i,
  input  wire logic                   bus_we_i,
  input  wire logic [31:0]            bus_addr_i,
  input  pito_mem_pkg::bus_be_t       bus_be_i,
  input  pito_mem_pkg::bus_data_t     bus_wdata_i,
  output logic                        bus_rvalid_o,
  output pito_mem_pkg::bus_data_t     bus_rdata_o,
  output logic                        bus_err_o,
  // Instruction bank
  output logic                        imem_req_o,
  output logic                        imem_we_o,
  output pito_mem_pkg::bank_idx_t     imem_idx_o,
  output pito_mem_pkg::bus_be_t       imem_be_o,
  output pito_mem_pkg::bus_data_t     imem_wdata_o,
  input  pito_mem_pkg::bus_data_t     imem_rdata_i,
  input  wire logic                   imem_rvalid_i,
  // Data bank
  output logic                        dmem_req_o,
  output logic                        dmem_we_o,
  output pito_mem_pkg::bank_idx_t     dmem_idx_o,
  output pito_mem_pkg::bus_be_t       dmem_be_o,
  output pito_mem_pkg::bus_data_t     dmem_wdata_o,
  input  pito_mem_pkg::bus_data_t     dmem_rdata_i,
  input  wire logic                   dmem_rvalid_i
);

  import pito_mem_pkg::*;

  localparam logic [31:0] IMEM_LIMIT = `PITO_IMEM_BASE + `PITO_REGION_BYTES;
  localparam logic [31:0] DMEM_LIMIT = `PITO_DMEM_BASE + `PITO_REGION_BYTES;

  mem_addr_u   addr_u;
  mem_region_e region;
  mem_region_e region_q;
  logic        err_q;

  // ==============================
  // Request steering
  // ==============================

  assign addr_u.flat = bus_addr_i;

  // Range check on the flat byte address
  always_comb begin
    region = NONE;
    if (addr_u.flat >= `PITO_IMEM_BASE && addr_u.flat < IMEM_LIMIT) begin
      region = IMEM;
    end else if (addr_u.flat >= `PITO_DMEM_BASE && addr_u.flat < DMEM_LIMIT) begin
      region = DMEM;
    end
  end

  assign imem_req_o   = bus_req_i & (region == IMEM);
  assign imem_we_o    = bus_we_i;
  assign imem_idx_o   = addr_u.fields.idx;
  assign imem_be_o    = bus_be_i;
  assign imem_wdata_o = bus_wdata_i;

  assign dmem_req_o   = bus_req_i & (region == DMEM);
  assign dmem_we_o    = bus_we_i;
  assign dmem_idx_o   = addr_u.fields.idx;
  assign dmem_be_o    = bus_be_i;
  assign dmem_wdata_o = bus_wdata_i;

  // ==============================
  // Response path
  // ==============================

  // Region and error line up with the bank rvalid cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      region_q <= NONE;
      err_q    <= 1'b0;
    end else begin
      err_q <= bus_req_i & (region == NONE);
      if (bus_req_i) begin
        region_q <= region;
      end
    end
  end

  always_comb begin
    case (region_q)
      IMEM:    bus_rdata_o = imem_rdata_i;
      DMEM:    bus_rdata_o = dmem_rdata_i;
      default: bus_rdata_o = '0;
    endcase
  end

  assign bus_rvalid_o = (imem_rvalid_i & (region_q == IMEM))
                      | (dmem_rvalid_i & (region_q == DMEM))
                      | err_q;
  assign bus_err_o    = err_q;

endmodule

`default_nettype wire

/* hw/pito_bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module pito_bus_arbiter (
  input  wire logic                   clk_i,
  input  wire logic                   rst_n_i,
  // Host loader port
  input  wire logic                   host_req_i,
  input  wire logic                   host_we_i,
  input  wire logic [31:0]            host_addr_i,
  input  pito_mem_pkg::bus_be_t       host_be_i,
  input  pito_mem_pkg::bus_data_t     host_wdata_i,
  output logic                        host_gnt_o,
  output logic                        host_rvalid_o,
  output pito_mem_pkg::bus_data_t     host_rdata_o,
  output logic                        host_err_o,
  // Core load/store port
  input  wire logic                   core_req_i,
  input  wire logic                   core_we_i,
  input  wire logic [31:0]            core_addr_i,
  input  pito_mem_pkg::bus_be_t       core_be_i,
  input  pito_mem_pkg::bus_data_t     core_wdata_i,
  output logic                        core_gnt_o,
  output logic                        core_rvalid_o,
  output pito_mem_pkg::bus_data_t     core_rdata_o,
  output logic                        core_err_o,
  // Shared internal bus
  output logic                        bus_req_o,
  output logic                        bus_we_o,
  output logic [31:0]                 bus_addr_o,
  output pito_mem_pkg::bus_be_t       bus_be_o,
  output pito_mem_pkg::bus_data_t     bus_wdata_o,
  input  wire logic                   bus_rvalid_i,
  input  pito_mem_pkg::bus_data_t     bus_rdata_i,
  input  wire logic                   bus_err_i
);

  // High when the core wins a tie
  logic prio_core_q;
  // Master that owns the response in flight
  logic resp_core_q;

  // ==============================
  // Grant
  // ==============================

  assign host_gnt_o = host_req_i & (~core_req_i | ~prio_core_q);
  assign core_gnt_o = core_req_i & (~host_req_i | prio_core_q);

  assign bus_req_o   = host_gnt_o | core_gnt_o;
  assign bus_we_o    = core_gnt_o ? core_we_i    : host_we_i;
  assign bus_addr_o  = core_gnt_o ? core_addr_i  : host_addr_i;
  assign bus_be_o    = core_gnt_o ? core_be_i    : host_be_i;
  assign bus_wdata_o = core_gnt_o ? core_wdata_i : host_wdata_i;

  // Pointer moves only when someone is granted
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prio_core_q <= 1'b0;
    end else if (bus_req_o) begin
      prio_core_q <= host_gnt_o;
    end
  end

  // ==============================
  // Response return
  // ==============================

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_core_q <= 1'b0;
    end else if (bus_req_o) begin
      resp_core_q <= core_gnt_o;
    end
  end

  assign host_rvalid_o = bus_rvalid_i & ~resp_core_q;
  assign core_rvalid_o = bus_rvalid_i & resp_core_q;

  assign host_err_o = host_rvalid_o & bus_err_i;
  assign core_err_o = core_rvalid_o & bus_err_i;

  // Idle port sees zero data
  assign host_rdata_o = host_rvalid_o ? bus_rdata_i : '0;
  assign core_rdata_o = core_rvalid_o ? bus_rdata_i : '0;

endmodule

`default_nettype wire

/* hw/pito_mem_macros.svh */
`ifndef PITO_MEM_MACROS_SVH
`define PITO_MEM_MACROS_SVH

// ==============================
// Memory map
// ==============================

// Instruction region, first byte
`define PITO_IMEM_BASE 32'h0020_0000

// Data region follows right after the instruction region
`define PITO_DMEM_BASE 32'h0020_2000

// Both regions are 8 KiB
`define PITO_REGION_BYTES 32'h0000_2000

// ==============================
// Bank geometry
// ==============================

// One bank covers one region of 32-bit words
`define PITO_BANK_WORDS 2048

// Width of a bus data word
`define PITO_DATA_W 32

`endif

/* hw/pito_mem_pkg.sv */
`default_nettype none

`include "pito_mem_macros.svh"

package pito_mem_pkg;

  // ==============================
  // Bus payload types
  // ==============================

  typedef logic [`PITO_DATA_W-1:0] bus_data_t;

  // One enable bit per byte lane
  typedef logic [`PITO_DATA_W/8-1:0] bus_be_t;

  // Word index inside one bank
  typedef logic [$clog2(`PITO_BANK_WORDS)-1:0] bank_idx_t;

  // ==============================
  // Address decoding
  // ==============================

  typedef enum logic [1:0] {
    IMEM = 2'd0,
    DMEM = 2'd1,
    NONE = 2'd2
  } mem_region_e;

  // Field layout of a 32-bit address, MSB first
  typedef struct packed {
    logic [17:0] tag;
    logic        bank_sel;
    bank_idx_t   idx;
    logic [1:0]  offset;
  } mem_addr_fields_t;

  // Same address seen flat for range checks or split into fields
  typedef union packed {
    logic [31:0]      flat;
    mem_addr_fields_t fields;
  } mem_addr_u;

endpackage

`default_nettype wire

/* hw/pito_mem_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module pito_mem_subsystem (
  input  wire logic                   clk_i,
  input  wire logic                   rst_n_i,
  // Host loader port
  input  wire logic                   host_req_i,
  input  wire logic                   host_we_i,
  input  wire logic [31:0]            host_addr_i,
  input  pito_mem_pkg::bus_be_t       host_be_i,
  input  pito_mem_pkg::bus_data_t     host_wdata_i,
  output logic                        host_gnt_o,
  output logic                        host_rvalid_o,
  output pito_mem_pkg::bus_data_t     host_rdata_o,
  output logic                        host_err_o,
  // Core load/store port
  input  wire logic                   core_req_i,
  input  wire logic                   core_we_i,
  input  wire logic [31:0]            core_addr_i,
  input  pito_mem_pkg::bus_be_t       core_be_i,
  input  pito_mem_pkg::bus_data_t     core_wdata_i,
  output logic                        core_gnt_o,
  output logic                        core_rvalid_o,
  output pito_mem_pkg::bus_data_t     core_rdata_o,
  output logic                        core_err_o
);

  import pito_mem_pkg::*;

  // ==============================
  // Internal bus
  // ==============================

  logic        bus_req;
  logic        bus_we;
  logic [31:0] bus_addr;
  bus_be_t     bus_be;
  bus_data_t   bus_wdata;
  logic        bus_rvalid;
  bus_data_t   bus_rdata;
  logic        bus_err;

  // Bank side
  logic        imem_req;
  logic        imem_we;
  bank_idx_t   imem_idx;
  bus_be_t     imem_be;
  bus_data_t   imem_wdata;
  bus_data_t   imem_rdata;
  logic        imem_rvalid;

  logic        dmem_req;
  logic        dmem_we;
  bank_idx_t   dmem_idx;
  bus_be_t     dmem_be;
  bus_data_t   dmem_wdata;
  bus_data_t   dmem_rdata;
  logic        dmem_rvalid;

  // ==============================
  // Arbitration
  // ==============================

  pito_bus_arbiter pito_bus_arbiter_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .host_req_i    (host_req_i),
    .host_we_i     (host_we_i),
    .host_addr_i   (host_addr_i),
    .host_be_i     (host_be_i),
    .host_wdata_i  (host_wdata_i),
    .host_gnt_o    (host_gnt_o),
    .host_rvalid_o (host_rvalid_o),
    .host_rdata_o  (host_rdata_o),
    .host_err_o    (host_err_o),
    .core_req_i    (core_req_i),
    .core_we_i     (core_we_i),
    .core_addr_i   (core_addr_i),
    .core_be_i     (core_be_i),
    .core_wdata_i  (core_wdata_i),
    .core_gnt_o    (core_gnt_o),
    .core_rvalid_o (core_rvalid_o),
    .core_rdata_o  (core_rdata_o),
    .core_err_o    (core_err_o),
    .bus_req_o     (bus_req),
    .bus_we_o      (bus_we),
    .bus_addr_o    (bus_addr),
    .bus_be_o      (bus_be),
    .bus_wdata_o   (bus_wdata),
    .bus_rvalid_i  (bus_rvalid),
    .bus_rdata_i   (bus_rdata),
    .bus_err_i     (bus_err)
  );

  // ==============================
  // Decode and banks
  // ==============================

  pito_addr_decoder pito_addr_decoder_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .bus_req_i     (bus_req),
    .bus_we_i      (bus_we),
    .bus_addr_i    (bus_addr),
    .bus_be_i      (bus_be),
    .bus_wdata_i   (bus_wdata),
    .bus_rvalid_o  (bus_rvalid),
    .bus_rdata_o   (bus_rdata),
    .bus_err_o     (bus_err),
    .imem_req_o    (imem_req),
    .imem_we_o     (imem_we),
    .imem_idx_o    (imem_idx),
    .imem_be_o     (imem_be),
    .imem_wdata_o  (imem_wdata),
    .imem_rdata_i  (imem_rdata),
    .imem_rvalid_i (imem_rvalid),
    .dmem_req_o    (dmem_req),
    .dmem_we_o     (dmem_we),
    .dmem_idx_o    (dmem_idx),
    .dmem_be_o     (dmem_be),
    .dmem_wdata_o  (dmem_wdata),
    .dmem_rdata_i  (dmem_rdata),
    .dmem_rvalid_i (dmem_rvalid)
  );

  // Instruction memory
  pito_sram_bank imem_bank_inst (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (imem_req),
    .we_i     (imem_we),
    .idx_i    (imem_idx),
    .be_i     (imem_be),
    .wdata_i  (imem_wdata),
    .rdata_o  (imem_rdata),
    .rvalid_o (imem_rvalid)
  );

  // Data memory
  pito_sram_bank dmem_bank_inst (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (dmem_req),
    .we_i     (dmem_we),
    .idx_i    (dmem_idx),
    .be_i     (dmem_be),
    .wdata_i  (dmem_wdata),
    .rdata_o  (dmem_rdata),
    .rvalid_o (dmem_rvalid)
  );

endmodule

`default_nettype wire

/* hw/pito_sram_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pito_mem_macros.svh"

module pito_sram_bank (
  input  wire logic                   clk_i,
  input  wire logic                   rst_n_i,
  input  wire logic                   req_i,
  input  wire logic                   we_i,
  input  pito_mem_pkg::bank_idx_t     idx_i,
  input  pito_mem_pkg::bus_be_t       be_i,
  input  pito_mem_pkg::bus_data_t     wdata_i,
  output pito_mem_pkg::bus_data_t     rdata_o,
  output logic                        rvalid_o
);

  import pito_mem_pkg::*;

  bus_data_t mem [`PITO_BANK_WORDS];
  bus_data_t rdata_q;
  logic      rvalid_q;

  // ==============================
  // Array access
  // ==============================

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        // Byte lanes update independently
        for (int b = 0; b < $bits(bus_be_t); b++) begin
          if (be_i[b]) begin
            mem[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
        rdata_q <= '0;
      end else begin
        rdata_q <= mem[idx_i];
      end
    end
  end

  // One-cycle response
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  assign rdata_o  = rdata_q;
  assign rvalid_o = rvalid_q;

endmodule

`default_nettype wire

/* sim.f */
+incdir+hw
hw/pito_mem_pkg.sv
hw/pito_bus_arbiter.sv
hw/pito_addr_decoder.sv
hw/pito_sram_bank.sv
hw/pito_mem_subsystem.sv
testbench/pito_mem_subsystem_properties.sv
testbench/pito_mem_subsystem_tb.sv

/* testbench/pito_mem_subsystem_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module pito_mem_subsystem_properties (
  input wire logic clk_i,
  input wire logic rst_n_i,
  input wire logic host_gnt_i,
  input wire logic host_rvalid_i,
  input wire logic host_err_i,
  input wire logic core_gnt_i,
  input wire logic core_rvalid_i,
  input wire logic core_err_i
);

  // ==============================
  // Arbitration
  // ==============================

  gnt_exclusive_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(host_gnt_i && core_gnt_i))
    else $error("host and core granted in the same cycle");

  // ==============================
  // Response timing
  // ==============================

  // Each grant answered on its own port one cycle later
  host_resp_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_gnt_i |=> host_rvalid_i)
    else $error("host grant without rvalid in the next cycle");

  core_resp_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    core_gnt_i |=> core_rvalid_i)
    else $error("core grant without rvalid in the next cycle");

  // And never a response without a grant before it
  host_only_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_rvalid_i |-> $past(host_gnt_i))
    else $error("host rvalid without a grant in the previous cycle");

  core_only_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    core_rvalid_i |-> $past(core_gnt_i))
    else $error("core rvalid without a grant in the previous cycle");

  // Quiet outputs while in reset
  reset_quiet_a : assert property (@(posedge clk_i)
    !rst_n_i |-> !(host_gnt_i || host_rvalid_i || host_err_i ||
                   core_gnt_i || core_rvalid_i || core_err_i))
    else $error("grant, rvalid or err active during reset");

endmodule

bind pito_mem_subsystem pito_mem_subsystem_properties pito_mem_subsystem_properties_inst (
  .clk_i         (clk_i),
  .rst_n_i       (rst_n_i),
  .host_gnt_i    (host_gnt_o),
  .host_rvalid_i (host_rvalid_o),
  .host_err_i    (host_err_o),
  .core_gnt_i    (core_gnt_o),
  .core_rvalid_i (core_rvalid_o),
  .core_err_i    (core_err_o)
);

`default_nettype wire

/* testbench/pito_mem_subsystem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pito_mem_macros.svh"

module pito_mem_subsystem_tb;

  import pito_mem_pkg::*;

  localparam int HOST = 0;
  localparam int CORE = 1;
  localparam int RESET_CYCLES = 10;
  localparam int N_IMEM = 16;
  localparam int N_DMEM = 8;
  localparam int N_SPLIT = 4;
  localparam int N_UNMAPPED = 4;
  localparam int N_BURST = 8;
  localparam int N_RAND = 40;
  localparam int TOTAL_ACCESSES = 2 * N_IMEM + 3 * N_DMEM + 4 * N_SPLIT + N_UNMAPPED
                                + N_IMEM + N_DMEM + 2 * N_BURST + 2 * N_RAND;
  localparam int TIMEOUT_CYCLES = 2 * TOTAL_ACCESSES + RESET_CYCLES;

  // Tag of both regions, above bank select, word index and byte offset
  localparam logic [17:0] REGION_TAG = 18'(`PITO_IMEM_BASE >> 14);

  logic        clk = 1'b0;
  logic        rst_n;
  logic        host_req;
  logic        host_we;
  logic [31:0] host_addr;
  bus_be_t     host_be;
  bus_data_t   host_wdata;
  logic        host_gnt;
  logic        host_rvalid;
  bus_data_t   host_rdata;
  logic        host_err;
  logic        core_req;
  logic        core_we;
  logic [31:0] core_addr;
  bus_be_t     core_be;
  bus_data_t   core_wdata;
  logic        core_gnt;
  logic        core_rvalid;
  bus_data_t   core_rdata;
  logic        core_err;

  // Pending ops {we, addr, be, wdata} and expected responses {err, rdata}
  logic [68:0] ops_q [2][$];
  logic [32:0] expected_q [2][$];
  bus_data_t   imem_model [`PITO_BANK_WORDS];
  bus_data_t   dmem_model [`PITO_BANK_WORDS];
  logic [31:0] lfsr_state = 32'd40;
  logic        last_winner_core = 1'b1;
  string       test_name = "reset";
  int          error_count = 0;
  int          cycle_count = 0;

  always #2 clk = ~clk;

  pito_mem_subsystem pito_mem_subsystem_inst (
    .clk_i (clk), .rst_n_i (rst_n),
    .host_req_i (host_req), .host_we_i (host_we), .host_addr_i (host_addr),
    .host_be_i (host_be), .host_wdata_i (host_wdata), .host_gnt_o (host_gnt),
    .host_rvalid_o (host_rvalid), .host_rdata_o (host_rdata), .host_err_o (host_err),
    .core_req_i (core_req), .core_we_i (core_we), .core_addr_i (core_addr),
    .core_be_i (core_be), .core_wdata_i (core_wdata), .core_gnt_o (core_gnt),
    .core_rvalid_o (core_rvalid), .core_rdata_o (core_rdata), .core_err_o (core_err)
  );

  // ==============================
  // Random source and addresses
  // ==============================

  // Galois LFSR, right shifting
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ({1'b0, s[31:1]} ^ 32'hD000_0001) : {1'b0, s[31:1]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  function automatic logic [31:0] make_addr(input mem_region_e region, input bank_idx_t idx,
                                            input logic [1:0] offset);
    mem_addr_u a;
    a.fields.tag      = (region == NONE) ? REGION_TAG + 18'd1 : REGION_TAG;
    a.fields.bank_sel = (region == DMEM);
    a.fields.idx      = idx;
    a.fields.offset   = offset;
    return a.flat;
  endfunction

  // ==============================
  // Reference model
  // ==============================

  function automatic logic [32:0] ref_access(input logic we, input logic [31:0] addr,
                                             input bus_be_t be, input bus_data_t wdata);
    logic        in_imem;
    logic        in_dmem;
    logic [31:0] off;
    bank_idx_t   idx;
    in_imem = addr >= `PITO_IMEM_BASE && addr < `PITO_IMEM_BASE + `PITO_REGION_BYTES;
    in_dmem = addr >= `PITO_DMEM_BASE && addr < `PITO_DMEM_BASE + `PITO_REGION_BYTES;
    if (!in_imem && !in_dmem) begin
      return {1'b1, 32'h0};
    end
    off = addr - (in_imem ? `PITO_IMEM_BASE : `PITO_DMEM_BASE);
    // Word index inside an 8 KiB region
    idx = off[12:2];
    if (!we) begin
      return {1'b0, in_imem ? imem_model[idx] : dmem_model[idx]};
    end
    for (int b = 0; b < $bits(bus_be_t); b++) begin
      if (be[b] && in_imem) begin
        imem_model[idx][8*b +: 8] = wdata[8*b +: 8];
      end else if (be[b]) begin
        dmem_model[idx][8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return {1'b0, 32'h0};
  endfunction

  // ==============================
  // Comparison
  // ==============================

  function automatic string port_name(input int port);
    return (port == CORE) ? "core" : "host";
  endfunction

  task automatic check_port(input int port, input logic rvalid, input bus_data_t rdata,
                            input logic err);
    logic [32:0] exp;
    if (rvalid) begin
      assert (expected_q[port].size() != 0) else begin
        error_count++;
        $display("%s port gave rvalid with no request outstanding", port_name(port));
      end
      if (expected_q[port].size() != 0) begin
        exp = expected_q[port].pop_front();
        assert (rdata === exp[31:0]) else begin
          error_count++;
          $display("Fail %s %s rdata: expected %h, actual %h",
                   test_name, port_name(port), exp[31:0], rdata);
        end
        assert (err === exp[32]) else begin
          error_count++;
          $display("Fail %s %s err: expected %b, actual %b",
                   test_name, port_name(port), exp[32], err);
        end
      end
    end
    // One cycle latency leaves nothing behind
    assert (expected_q[port].size() == 0) else begin
      error_count++;
      $display("%s port got no response one cycle after acceptance", port_name(port));
      expected_q[port].delete();
    end
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      check_port(HOST, host_rvalid, host_rdata, host_err);
      check_port(CORE, core_rvalid, core_rdata, core_err);
      // Tie goes to the master not granted last
      if (host_req && core_req) begin
        assert (host_gnt === last_winner_core && core_gnt === !last_winner_core) else begin
          error_count++;
          $display("Fail %s arbitration host_gnt: expected %b, actual %b",
                   test_name, last_winner_core, host_gnt);
        end
      end
      if (host_req && host_gnt) begin
        expected_q[HOST].push_back(ref_access(host_we, host_addr, host_be, host_wdata));
        last_winner_core = 1'b0;
      end else if (core_req && core_gnt) begin
        expected_q[CORE].push_back(ref_access(core_we, core_addr, core_be, core_wdata));
        last_winner_core = 1'b1;
      end
    end
  end

  // ==============================
  // Drivers
  // ==============================

  task automatic drive_port(input int port, input logic req, input logic [68:0] op);
    if (port == CORE) begin
      core_req   = req;
      core_we    = op[68];
      core_addr  = op[67:36];
      core_be    = op[35:32];
      core_wdata = op[31:0];
    end else begin
      host_req   = req;
      host_we    = op[68];
      host_addr  = op[67:36];
      host_be    = op[35:32];
      host_wdata = op[31:0];
    end
  endtask

  task automatic queue_op(input int port, input logic we, input logic [31:0] addr,
                          input bus_be_t be, input bus_data_t wdata);
    ops_q[port].push_back({we, addr, be, wdata});
  endtask

  task automatic drain_port(input int port);
    logic [68:0] op;
    while (ops_q[port].size() != 0) begin
      op = ops_q[port].pop_front();
      drive_port(port, 1'b1, op);
      // Hold the request until granted
      @(negedge clk);
      while (!((port == CORE) ? core_gnt : host_gnt)) begin
        @(negedge clk);
      end
      @(posedge clk);
      #0.5;
    end
    drive_port(port, 1'b0, '0);
  endtask

  task automatic run_ports();
    fork
      drain_port(HOST);
      drain_port(CORE);
    join
    while (expected_q[HOST].size() != 0 || expected_q[CORE].size() != 0) begin
      @(posedge clk);
      #0.5;
    end
  endtask

  task automatic finish_run(input logic timed_out);
    if (timed_out) begin
      $display("Timeout after %0d cycles, traffic did not complete", cycle_count);
    end
    $display("Summary: %0d errors, %0d timeouts, %0d cycles",
             error_count, timed_out ? 1 : 0, cycle_count);
    if (error_count == 0 && !timed_out) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      finish_run(1'b1);
    end
  end

  // ==============================
  // Tests
  // ==============================

  initial begin
    bus_data_t   word;
    mem_region_e region;
    logic [1:0]  sel;
    rst_n = 1'b0;
    drive_port(HOST, 1'b0, '0);
    drive_port(CORE, 1'b0, '0);
    repeat (RESET_CYCLES) @(posedge clk);
    #0.5;
    rst_n = 1'b1;

    test_name = "imem_full_word";
    for (int i = 0; i < N_IMEM; i++) begin
      queue_op(HOST, 1'b1, make_addr(IMEM, 11'(i), 2'd0), 4'hF, rand_bits(32));
    end
    for (int i = 0; i < N_IMEM; i++) begin
      queue_op(HOST, 1'b0, make_addr(IMEM, 11'(i), 2'd0), 4'hF, '0);
    end
    run_ports();

    // Full preload, then byte lane updates from the core
    test_name = "dmem_byte_enable";
    for (int i = 0; i < N_DMEM; i++) begin
      queue_op(CORE, 1'b1, make_addr(DMEM, 11'(i), 2'd0), 4'hF, rand_bits(32));
    end
    for (int i = 0; i < N_DMEM; i++) begin
      queue_op(CORE, 1'b1, make_addr(DMEM, 11'(i), 2'd0), 4'(i + 1), rand_bits(32));
    end
    for (int i = 0; i < N_DMEM; i++) begin
      queue_op(CORE, 1'b0, make_addr(DMEM, 11'(i), 2'd0), 4'hF, '0);
    end
    run_ports();

    test_name = "region_split";
    for (int i = 0; i < N_SPLIT; i++) begin
      word = rand_bits(32);
      queue_op(HOST, 1'b1, make_addr(IMEM, 11'(2040 + i), 2'd0), 4'hF, word);
      queue_op(HOST, 1'b1, make_addr(DMEM, 11'(2040 + i), 2'd0), 4'hF, ~word);
    end
    for (int i = 0; i < N_SPLIT; i++) begin
      queue_op(HOST, 1'b0, make_addr(IMEM, 11'(2040 + i), 2'd0), 4'hF, '0);
      queue_op(HOST, 1'b0, make_addr(DMEM, 11'(2040 + i), 2'd0), 4'hF, '0);
    end
    run_ports();

    test_name = "unmapped";
    for (int i = 0; i < N_UNMAPPED; i++) begin
      queue_op(HOST, 1'(i < 2), make_addr(NONE, 11'(i % 2), 2'd0), 4'hF, rand_bits(32));
    end
    for (int i = 0; i < N_IMEM; i++) begin
      queue_op(HOST, 1'b0, make_addr(IMEM, 11'(i), 2'd0), 4'hF, '0);
    end
    for (int i = 0; i < N_DMEM; i++) begin
      queue_op(HOST, 1'b0, make_addr(DMEM, 11'(i), 2'd0), 4'hF, '0);
    end
    run_ports();

    // Both masters back to back
    test_name = "round_robin";
    for (int i = 0; i < N_BURST; i++) begin
      queue_op(HOST, 1'b0, make_addr(IMEM, 11'(i), 2'd0), 4'hF, '0);
      queue_op(CORE, 1'b0, make_addr(DMEM, 11'(i), 2'd0), 4'hF, '0);
    end
    run_ports();

    // Word indices 0 to 7 already hold known data in both banks
    test_name = "random_mix";
    for (int i = 0; i < N_RAND; i++) begin
      for (int p = 0; p < 2; p++) begin
        sel = 2'(rand_bits(2));
        region = (sel == 2'd2) ? NONE : (sel[0] ? DMEM : IMEM);
        queue_op(p, 1'(rand_bits(1)),
                 make_addr(region, 11'(rand_bits(3)), 2'(rand_bits(2))),
                 4'(rand_bits(4)), rand_bits(32));
      end
    end
    run_ports();

    finish_run(1'b0);
  end

endmodule

`default_nettype wire
